//--- all.f
+incdir+src
src/agc_pkg.sv
src/central_regs.sv
src/rom_bank_map.sv
src/ram_bank_map.sv
src/addr_translate.sv
src/agc_mem_unit.sv
tb/tb_clock.sv
tb/agc_mem_unit_props.sv
tb/tb_agc_mem_unit.sv

//--- tb/tb_agc_mem_unit.sv
// Testbench for the guidance computer register and addressing front end
// Directed and seeded random stimulus, value checks beside the bound assertions

`include "agc_cfg.svh"

module tb_agc_mem_unit
  import agc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  // Run limit in clock cycles
  localparam int MAX_CYCLES = 1000;

  logic       clk;
  logic       rst_l;
  reg_write_t wr1;
  reg_write_t wr2;
  reg_sel_t   rs1_sel;
  reg_sel_t   rs2_sel;
  word_t      rs1_data;
  word_t      rs2_data;
  soft_addr_t addr_pc;
  soft_addr_t addr_r;
  soft_addr_t addr_w;
  logic       mem_write_req;
  rom_addr_t  rom_addr_pc;
  read_xlat_t read_addr;
  ram_addr_t  ram_addr_w;
  logic       ram_write_en;

  integer seed = 32'ha20a;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     mark = 0;
  // Expected read view per selector, bank views follow the bank bits
  word_t  model [16];
  bank_t  eb_m;
  bank_t  fb_m;

  tb_clock #(.PERIOD_NS(40)) u_clk (.clk(clk));

  agc_mem_unit UUT (.*);

  // Banked fixed memory sits above the fixed-fixed image
  function automatic rom_addr_t rom_map(soft_addr_t a, bank_t fb);
    if (a >= `AGC_ROM_FIXED_BASE)
      return rom_addr_t'(a - `AGC_ROM_FIXED_BASE);
    return rom_addr_t'(a + `AGC_ROM_BASE + fb * `AGC_ROM_BANK_SIZE);
  endfunction

  // Banked erasable window moved by EB or into the upper half
  function automatic ram_addr_t ram_map(soft_addr_t a, bank_t eb);
    int off;
    off = 0;
    if (a >= `AGC_RAM_BANKED_BASE)
      off = eb[2] ? `AGC_RAM_HIGH_OFFSET : eb[1:0] * `AGC_RAM_BANK_SIZE;
    return ram_addr_t'(a[10:0] + off);
  endfunction

  task automatic compare(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
    end
  endtask

  // Rising edge, then the drive delay
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  // One write cycle, both read ports watch the target register
  task automatic write_reg(bit use_port2, reg_sel_t sel, word_t d);
    step();
    if (use_port2)
      wr2 = {1'b1, sel, d};
    else
      wr1 = {1'b1, sel, d};
    rs1_sel = sel;
    rs2_sel = sel;
    #10;
    compare("rs1_data forwarded", d, rs1_data);
    compare("rs2_data forwarded", d, rs2_data);
    step();
    wr1.en = 1'b0;
    wr2.en = 1'b0;
    case (sel)
      EB:  eb_m = d[11:9];
      FB:  fb_m = d[14:12];
      BB: begin
        eb_m = d[11:9];
        fb_m = d[14:12];
      end
      // Rotates wrap the end bit, SR keeps the sign
      CYR: model[CYR] = (d >> 1) | (d << 14);
      SR:  model[SR] = (d >> 1) | (d & 15'h4000);
      CYL: model[CYL] = (d << 1) | (d >> 14);
      SL:  model[SL] = d << 1;
      ZERO: ;
      default: model[sel] = d;
    endcase
    model[EB] = {3'b000, eb_m, 9'd0};
    model[FB] = {fb_m, 12'd0};
    model[BB] = {fb_m, eb_m, 9'd0};
  endtask

  // Stored value on both read ports, no write in flight
  task automatic read_check(reg_sel_t sel);
    step();
    rs1_sel = sel;
    rs2_sel = sel;
    #10;
    compare({"rs1_data ", sel.name()}, model[sel], rs1_data);
    compare({"rs2_data ", sel.name()}, model[sel], rs2_data);
  endtask

  task automatic end_test(string name);
    int total;
    total = errors + int'(UUT.u_props.fail_count);
    tests++;
    $display("Test %0d, %s, %0d failures", tests, name, total - mark);
    mark = total;
  endtask

  initial begin
    reg_sel_t    plain [5];
    reg_sel_t    edit [4];
    logic [31:0] r;
    word_t       d;
    word_t       d2;
    word_t       d3;
    plain = '{A, L, Q, TIME1, TIME2};
    edit = '{CYR, SR, CYL, SL};
    model = '{default: '0};
    eb_m = '0;
    fb_m = '0;
    rst_l = 1'b0;
    wr1 = '0;
    wr2 = '0;
    rs1_sel = A;
    rs2_sel = A;
    addr_pc = '0;
    addr_r = '0;
    addr_w = '0;
    mem_write_req = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_l = 1'b1;

    for (int i = 0; i < 13; i++)
      read_check(reg_sel_t'(i));
    compare("ram_write_en", 0, ram_write_en);
    end_test("reset clears every register");

    foreach (plain[i]) begin
      write_reg(bit'(i % 2), plain[i], word_t'($random(seed)));
      read_check(plain[i]);
    end
    // Both ports on Q in one cycle
    d = word_t'($random(seed));
    step();
    wr1 = {1'b1, Q, d};
    wr2 = {1'b1, Q, ~d};
    rs1_sel = Q;
    rs2_sel = Q;
    step();
    wr1.en = 1'b0;
    wr2.en = 1'b0;
    model[Q] = ~d;
    read_check(Q);
    end_test("plain writes and port 2 precedence");

    // Fixed word hits the sign and end bits
    foreach (edit[i]) begin
      write_reg(1'b1, edit[i], 15'h4001);
      read_check(edit[i]);
      write_reg(1'b0, edit[i], word_t'($random(seed)));
      read_check(edit[i]);
    end
    end_test("editing register shifts and rotates");

    // Enables dropped one per cycle, idle ports keep data unlike storage
    d = word_t'($random(seed));
    d2 = word_t'($random(seed));
    d3 = ~d2;
    step();
    wr1 = {1'b1, L, d};
    wr2 = {1'b1, L, d2};
    rs1_sel = L;
    rs2_sel = L;
    #10;
    compare("rs1_data port 1 first", d, rs1_data);
    compare("rs2_data port 1 first", d, rs2_data);
    step();
    // Port 2 won the clash at the edge
    model[L] = d2;
    wr1.en = 1'b0;
    wr2.data = d3;
    #10;
    compare("rs1_data port 2", d3, rs1_data);
    compare("rs2_data port 2", d3, rs2_data);
    step();
    model[L] = d3;
    wr2.en = 1'b0;
    wr2.data = d;
    #10;
    compare("rs1_data stored", model[L], rs1_data);
    compare("rs2_data stored", model[L], rs2_data);
    end_test("write to read forwarding");

    write_reg(1'b0, EB, word_t'($random(seed)));
    read_check(EB);
    write_reg(1'b1, FB, word_t'($random(seed)));
    read_check(FB);
    for (int b = 0; b < 4; b++) begin
      write_reg(bit'(b % 2), BB, word_t'($random(seed)));
      read_check(BB);
      for (int k = 0; k < 8; k++) begin
        r = $random(seed);
        step();
        addr_pc = r[11:0];
        // About half the reads land in erasable memory
        addr_r = r[31] ? {2'b00, r[21:12]} : r[23:12];
        #10;
        compare("rom_addr_pc", rom_map(addr_pc, fb_m), rom_addr_pc);
        if (addr_r >= `AGC_ROM_BASE) begin
          compare("read_addr.rom", rom_map(addr_r, fb_m), read_addr.rom);
          compare("read_addr.ram", 0, read_addr.ram);
        end else begin
          compare("read_addr.rom", `AGC_ROM_IDLE_ADDR, read_addr.rom);
          compare("read_addr.ram", ram_map(addr_r, eb_m), read_addr.ram);
        end
      end
    end
    end_test("bank views and read translation");

    for (int k = 0; k < 24; k++) begin
      r = $random(seed);
      step();
      mem_write_req = 1'b1;
      addr_w = r[31] ? {2'b00, r[9:0]} : r[11:0];
      #10;
      compare("ram_write_en", addr_w < `AGC_ROM_BASE, ram_write_en);
      compare("ram_addr_w", ram_map(addr_w, eb_m), ram_addr_w);
    end
    step();
    mem_write_req = 1'b0;
    addr_w = '0;
    #10;
    compare("ram_write_en", 0, ram_write_en);
    end_test("write protect and write address");

    // Last cycle still goes through the assertions
    step();
    $display("Summary %0d tests, %0d checks, %0d value errors, %0d assertion failures",
             tests, checks, errors, UUT.u_props.fail_count);
    if (errors == 0 && UUT.u_props.fail_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

  // Run limit
  initial begin
    repeat (MAX_CYCLES) @(posedge clk);
    $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- tb/agc_mem_unit_props.sv
// Bound assertions for the guidance computer front end
// Forwarding, ZERO and bank read views, read steering and write protect

`include "agc_cfg.svh"

module agc_mem_unit_props
  import agc_pkg::*;
(
  input logic       clk,
  input logic       rst_l,
  input reg_write_t wr1,
  input reg_write_t wr2,
  input reg_sel_t   rs1_sel,
  input reg_sel_t   rs2_sel,
  input word_t      rs1_data,
  input word_t      rs2_data,
  input soft_addr_t addr_r,
  input soft_addr_t addr_w,
  input logic       mem_write_req,
  input read_xlat_t read_addr,
  input logic       ram_write_en,
  input bank_bits_t bank_bits
);
  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions so far, read by the testbench top
  int unsigned fail_count = 0;

  // Selector hits of each write port on each read port
  logic rs1_w1;
  logic rs1_w2;
  logic rs2_w1;
  logic rs2_w2;
  // Read port 1 returns storage
  logic rs1_stored;

  assign rs1_w1     = wr1.en && (wr1.sel == rs1_sel);
  assign rs1_w2     = wr2.en && (wr2.sel == rs1_sel);
  assign rs2_w1     = wr1.en && (wr1.sel == rs2_sel);
  assign rs2_w2     = wr2.en && (wr2.sel == rs2_sel);
  assign rs1_stored = !rs1_w1 && !rs1_w2;

  task automatic count_failure(string what);
    fail_count++;
    $error("%s", what);
  endtask

  // Port 1 data first, then port 2
  a_fwd_rs1: assert property (@(posedge clk) disable iff (!rst_l)
    (rs1_w1 || rs1_w2) |-> rs1_data == (rs1_w1 ? wr1.data : wr2.data))
    else count_failure("read port 1 missed the forwarded write data");
  a_fwd_rs2: assert property (@(posedge clk) disable iff (!rst_l)
    (rs2_w1 || rs2_w2) |-> rs2_data == (rs2_w1 ? wr1.data : wr2.data))
    else count_failure("read port 2 missed the forwarded write data");

  a_zero: assert property (@(posedge clk) disable iff (!rst_l)
    (rs1_stored && rs1_sel == ZERO) |-> rs1_data == '0)
    else count_failure("ZERO register read back a nonzero word");

  // Nothing from the ROM base up is writable
  a_protect: assert property (@(posedge clk) disable iff (!rst_l)
    ram_write_en |-> mem_write_req && (addr_w < `AGC_ROM_BASE))
    else count_failure("RAM write enabled outside erasable memory or without request");

  // Unused side of a read parked at its idle address
  a_idle: assert property (@(posedge clk) disable iff (!rst_l)
    (addr_r < `AGC_ROM_BASE) ? (read_addr.rom == `AGC_ROM_IDLE_ADDR)
                             : (read_addr.ram == '0))
    else count_failure("unused side of the read translation not at its idle address");

  // Bank views built from the six stored bits
  a_eb_view: assert property (@(posedge clk) disable iff (!rst_l)
    (rs1_stored && rs1_sel == EB) |-> rs1_data == {3'b000, bank_bits.eb, 9'd0})
    else count_failure("EB read view badly formatted");
  a_fb_view: assert property (@(posedge clk) disable iff (!rst_l)
    (rs1_stored && rs1_sel == FB) |-> rs1_data == {bank_bits.fb, 12'd0})
    else count_failure("FB read view badly formatted");
  a_bb_view: assert property (@(posedge clk) disable iff (!rst_l)
    (rs1_stored && rs1_sel == BB) |-> rs1_data == {bank_bits.fb, bank_bits.eb, 9'd0})
    else count_failure("BB read view badly formatted");

endmodule

bind agc_mem_unit agc_mem_unit_props u_props (.*);

//--- tb/tb_clock.sv
// Testbench clock source
// Free running with an even duty cycle

module tb_clock #(
  parameter int PERIOD_NS = 40
) (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

endmodule

//--- src/agc_mem_unit.sv
// Register and memory addressing front end of the guidance computer
// Central register file feeding the bank bits to address translation

module agc_mem_unit
  import agc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  // Register file ports
  input  reg_write_t wr1,
  input  reg_write_t wr2,
  input  reg_sel_t   rs1_sel,
  input  reg_sel_t   rs2_sel,
  output word_t      rs1_data,
  output word_t      rs2_data,
  // Software addresses
  input  soft_addr_t addr_pc,
  input  soft_addr_t addr_r,
  input  soft_addr_t addr_w,
  input  logic       mem_write_req,
  // Physical addresses
  output rom_addr_t  rom_addr_pc,
  output read_xlat_t read_addr,
  output ram_addr_t  ram_addr_w,
  output logic       ram_write_en
);

  // Stored EB and FB, a bank write shows up here after its edge
  bank_bits_t bank_bits;

  central_regs u_regs (
    .clk      (clk),
    .rst_l    (rst_l),
    .wr1      (wr1),
    .wr2      (wr2),
    .rs1_sel  (rs1_sel),
    .rs2_sel  (rs2_sel),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .banks    (bank_bits)
  );

  addr_translate u_xlat (
    .addr_pc       (addr_pc),
    .addr_r        (addr_r),
    .addr_w        (addr_w),
    .banks         (bank_bits),
    .mem_write_req (mem_write_req),
    .rom_addr_pc   (rom_addr_pc),
    .read_addr     (read_addr),
    .ram_addr_w    (ram_addr_w),
    .ram_write_en  (ram_write_en)
  );

endmodule

//--- src/addr_translate.sv
// Address translation for instruction fetch, data read and data write
// Read is steered to ROM or RAM, writes outside erasable are blocked

`include "agc_cfg.svh"

module addr_translate
  import agc_pkg::*;
(
  input  soft_addr_t addr_pc,
  input  soft_addr_t addr_r,
  input  soft_addr_t addr_w,
  input  bank_bits_t banks,
  input  logic       mem_write_req,
  output rom_addr_t  rom_addr_pc,
  output read_xlat_t read_addr,
  output ram_addr_t  ram_addr_w,
  output logic       ram_write_en
);

  // Both candidate translations of the read address
  rom_addr_t rd_rom;
  ram_addr_t rd_ram;
  // Read targets fixed memory
  logic      rd_is_rom;
  // Write lands in erasable memory
  logic      wr_is_ram;

  // Instruction fetch always goes to ROM
  rom_bank_map u_rom_pc (
    .addr     (addr_pc),
    .fb       (banks.fb),
    .rom_addr (rom_addr_pc)
  );

  rom_bank_map u_rom_rd (
    .addr     (addr_r),
    .fb       (banks.fb),
    .rom_addr (rd_rom)
  );

  ram_bank_map u_ram_rd (
    .addr     (addr_r),
    .eb       (banks.eb),
    .ram_addr (rd_ram)
  );

  ram_bank_map u_ram_wr (
    .addr     (addr_w),
    .eb       (banks.eb),
    .ram_addr (ram_addr_w)
  );

  assign rd_is_rom = (addr_r >= `AGC_ROM_BASE);

  // Unused side parked at its idle address
  assign read_addr.rom = rd_is_rom ? rd_rom : rom_addr_t'(`AGC_ROM_IDLE_ADDR);
  assign read_addr.ram = rd_is_rom ? '0 : rd_ram;

  // Write protect for everything from ROM base up
  assign wr_is_ram    = (addr_w < `AGC_ROM_BASE);
  assign ram_write_en = wr_is_ram ? mem_write_req : 1'b0;

endmodule

//--- src/ram_bank_map.sv
// Erasable memory address map
// Software address to 11-bit RAM address through the EB bank

`include "agc_cfg.svh"

module ram_bank_map
  import agc_pkg::*;
(
  input  soft_addr_t addr,
  input  bank_t      eb,
  output ram_addr_t  ram_addr
);

  // Unbanked erasable below the banked window
  logic      is_unbanked;
  ram_addr_t low_addr;
  // Offset from the low EB bits, then the high override
  ram_addr_t bank_off_low;
  ram_addr_t bank_off;

  assign is_unbanked = (addr < `AGC_RAM_BANKED_BASE);
  assign low_addr    = addr[`AGC_RAM_ADDR_W-1:0];

  // Four banks of 0400 words
  always_comb begin
    case (eb[1:0])
      2'd0:    bank_off_low = ram_addr_t'(0);
      2'd1:    bank_off_low = ram_addr_t'(`AGC_RAM_BANK_SIZE * 1);
      2'd2:    bank_off_low = ram_addr_t'(`AGC_RAM_BANK_SIZE * 2);
      default: bank_off_low = ram_addr_t'(`AGC_RAM_BANK_SIZE * 3);
    endcase
  end

  // Top EB bit selects the upper half, low bits ignored then
  assign bank_off = eb[2] ? ram_addr_t'(`AGC_RAM_HIGH_OFFSET) : bank_off_low;

  assign ram_addr = is_unbanked ? low_addr : low_addr + bank_off;

endmodule

//--- src/rom_bank_map.sv
// Fixed memory address map
// Software address to 14-bit ROM address through the FB bank

`include "agc_cfg.svh"

module rom_bank_map
  import agc_pkg::*;
(
  input  soft_addr_t addr,
  input  bank_t      fb,
  output rom_addr_t  rom_addr
);

  // Fixed-fixed region, FB has no effect there
  logic      is_fixed;
  rom_addr_t fixed_addr;
  // Banked region
  rom_addr_t bank_off;
  rom_addr_t banked_addr;

  assign is_fixed = (addr >= `AGC_ROM_FIXED_BASE);

  // Fixed-fixed sits at the bottom of ROM
  assign fixed_addr = rom_addr_t'(addr) - rom_addr_t'(`AGC_ROM_FIXED_BASE);

  // Bank offset by table, no multiplier
  always_comb begin
    case (fb)
      3'd0:    bank_off = rom_addr_t'(0);
      3'd1:    bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 1);
      3'd2:    bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 2);
      3'd3:    bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 3);
      3'd4:    bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 4);
      3'd5:    bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 5);
      3'd6:    bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 6);
      default: bank_off = rom_addr_t'(`AGC_ROM_BANK_SIZE * 7);
    endcase
  end

  // Banked window placed above the fixed-fixed image
  assign banked_addr = rom_addr_t'(addr) + rom_addr_t'(`AGC_ROM_BASE) + bank_off;

  assign rom_addr = is_fixed ? fixed_addr : banked_addr;

endmodule

//--- src/central_regs.sv
// Central register file of the guidance computer
// Two write ports, two forwarding read ports, editing and bank registers

module central_regs
  import agc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  input  reg_write_t wr1,
  input  reg_write_t wr2,
  input  reg_sel_t   rs1_sel,
  input  reg_sel_t   rs2_sel,
  output word_t      rs1_data,
  output word_t      rs2_data,
  output bank_bits_t banks
);

  // Accumulators and return address register
  word_t acc_a;
  word_t acc_l;
  word_t link_q;
  // Editing registers keep the already shifted word
  word_t ed_cyr;
  word_t ed_sr;
  word_t ed_cyl;
  word_t ed_sl;
  // Timers
  word_t time1;
  word_t time2;
  // Single copy of the bank bits, EB FB and BB are views of it
  bank_bits_t bank_q;

  // Write ports in priority order, later entry wins
  reg_write_t wr_port [2];
  // Stored value seen by each selector code
  word_t view [2**$bits(reg_sel_t)];

  assign wr_port[0] = wr1;
  assign wr_port[1] = wr2;

  // Forwarding chain for one read port
  // Port 1 is checked first, then port 2, then storage
  function automatic word_t read_port(reg_sel_t sel, reg_write_t w1, reg_write_t w2,
                                      word_t stored);
    if (w1.en && (w1.sel == sel)) begin
      return w1.data;
    end else if (w2.en && (w2.sel == sel)) begin
      return w2.data;
    end
    return stored;
  endfunction

  always_ff @(posedge clk or negedge rst_l) begin
    if (!rst_l) begin
      acc_a  <= '0;
      acc_l  <= '0;
      link_q <= '0;
      ed_cyr <= '0;
      ed_sr  <= '0;
      ed_cyl <= '0;
      ed_sl  <= '0;
      time1  <= '0;
      time2  <= '0;
      bank_q <= '0;
    end else begin
      // Port 1 then port 2, so port 2 overrides on a clash
      for (int p = 0; p < 2; p++) begin
        if (wr_port[p].en) begin
          case (wr_port[p].sel)
            A:     acc_a  <= wr_port[p].data;
            L:     acc_l  <= wr_port[p].data;
            Q:     link_q <= wr_port[p].data;
            // Only the pertinent bank bits are kept
            EB:    bank_q.eb <= wr_port[p].data[11:9];
            FB:    bank_q.fb <= wr_port[p].data[14:12];
            BB: begin
              bank_q.fb <= wr_port[p].data[14:12];
              bank_q.eb <= wr_port[p].data[11:9];
            end
            // Rotate right one place
            CYR:   ed_cyr <= {wr_port[p].data[0], wr_port[p].data[14:1]};
            // Shift right, sign bit copied
            SR:    ed_sr  <= {wr_port[p].data[14], wr_port[p].data[14:1]};
            // Rotate left one place
            CYL:   ed_cyl <= {wr_port[p].data[13:0], wr_port[p].data[14]};
            // Shift left, zero in
            SL:    ed_sl  <= {wr_port[p].data[13:0], 1'b0};
            TIME1: time1  <= wr_port[p].data;
            TIME2: time2  <= wr_port[p].data;
            // ZERO and unused codes drop the write
            default: ;
          endcase
        end
      end
    end
  end

  // Stored views, bank registers formatted into their word positions
  always_comb begin
    view        = '{default: '0};
    view[A]     = acc_a;
    view[L]     = acc_l;
    view[Q]     = link_q;
    view[EB]    = {3'b000, bank_q.eb, 9'd0};
    view[FB]    = {bank_q.fb, 12'd0};
    view[BB]    = {bank_q.fb, bank_q.eb, 9'd0};
    view[CYR]   = ed_cyr;
    view[SR]    = ed_sr;
    view[CYL]   = ed_cyl;
    view[SL]    = ed_sl;
    view[TIME1] = time1;
    view[TIME2] = time2;
  end

  assign rs1_data = read_port(rs1_sel, wr1, wr2, view[rs1_sel]);
  assign rs2_data = read_port(rs2_sel, wr1, wr2, view[rs2_sel]);

  // Raw bank bits for address translation
  assign banks = bank_q;

endmodule

//--- src/agc_pkg.sv
// Shared types of the guidance computer front end
// Width typedefs, register selector and bundled port structs

`include "agc_cfg.svh"

package agc_pkg;

  // Widths with a meaning
  typedef logic [`AGC_WORD_W-1:0]      word_t;
  typedef logic [`AGC_SOFT_ADDR_W-1:0] soft_addr_t;
  typedef logic [`AGC_ROM_ADDR_W-1:0]  rom_addr_t;
  typedef logic [`AGC_RAM_ADDR_W-1:0]  ram_addr_t;
  typedef logic [`AGC_BANK_W-1:0]      bank_t;

  // Central register selector
  // Codes 13 to 15 are unused and read as zero
  typedef enum logic [3:0] {
    A     = 4'd0,
    L     = 4'd1,
    Q     = 4'd2,
    EB    = 4'd3,
    FB    = 4'd4,
    BB    = 4'd5,
    ZERO  = 4'd6,
    CYR   = 4'd7,
    SR    = 4'd8,
    CYL   = 4'd9,
    SL    = 4'd10,
    TIME1 = 4'd11,
    TIME2 = 4'd12
  } reg_sel_t;

  // One register file write port
  typedef struct packed {
    logic     en;
    reg_sel_t sel;
    word_t    data;
  } reg_write_t;

  // Stored bank bits handed to address translation
  typedef struct packed {
    bank_t eb;
    bank_t fb;
  } bank_bits_t;

  // One translated data read, only one side is live
  typedef struct packed {
    rom_addr_t rom;
    ram_addr_t ram;
  } read_xlat_t;

endpackage

//--- src/agc_cfg.svh
// Guidance computer configuration
// Word and address widths, memory region bounds in octal

`ifndef AGC_CFG_SVH
`define AGC_CFG_SVH

// One's complement data word
`define AGC_WORD_W          15

// Software, fixed memory and erasable memory address widths
`define AGC_SOFT_ADDR_W     12
`define AGC_ROM_ADDR_W      14
`define AGC_RAM_ADDR_W      11

// EB and FB fields are both three bits
`define AGC_BANK_W          3

// Erasable memory, banked window starts here
`define AGC_RAM_BANKED_BASE 'o1400
`define AGC_RAM_BANK_SIZE   'o0400
// Upper half of erasable, selected by the top EB bit
`define AGC_RAM_HIGH_OFFSET 'o2000

// Fixed memory, everything from here up is not erasable
`define AGC_ROM_BASE        'o2000
// Fixed-fixed region, not affected by FB
`define AGC_ROM_FIXED_BASE  'o4000
`define AGC_ROM_BANK_SIZE   'o2000
// Parked ROM address while a read goes to erasable
`define AGC_ROM_IDLE_ADDR   'o2000

`endif
